/* src/cache_cfg.svh */
// Data cache size configuration
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Associativity and geometry of the cache
`define CACHE_WAYS 4
`define CACHE_SETS 16
`define LINE_WORDS 4

// Address is word addressed, so a line is LINE_WORDS consecutive addresses
`define ADDR_W 16
`define DATA_W 32

// Nonzero start value for the victim LFSR
`define LFSR_SEED 16'hACE1

`endif

/* src/cache_pkg.sv */
// Data cache types
`include "cache_cfg.svh"

package cache_pkg;

	// Way number within a set
	typedef logic [$clog2(`CACHE_WAYS)-1:0] way_t;

	// Set index
	typedef logic [$clog2(`CACHE_SETS)-1:0] index_t;

	// Word position inside a line
	typedef logic [$clog2(`LINE_WORDS)-1:0] offset_t;

	// Tag takes whatever address bits are left above index and offset
	typedef logic [`ADDR_W-$bits(index_t)-$bits(offset_t)-1:0] tag_t;

	// A whole line, word 0 in the low bits
	typedef logic [`LINE_WORDS-1:0][`DATA_W-1:0] line_t;

	// CPU word address split into its cache fields
	typedef struct packed {
		tag_t    tag;
		index_t  index;
		offset_t offset;
	} cache_addr_t;

	// Controller FSM states
	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		RESPOND,
		FILL,
		STORE
	} ctrl_state_t;

endpackage

/* src/mem_bus_pkg.sv */
// Memory bus types
`include "cache_cfg.svh"

package mem_bus_pkg;

	// One data word on the bus
	typedef logic [`DATA_W-1:0] word_t;

	// One word address on the bus
	typedef logic [`ADDR_W-1:0] maddr_t;

	// Peer that currently holds the bus
	typedef enum logic {
		OWN_FILL,
		OWN_STORE
	} owner_t;

endpackage

/* src/way_ram.sv */
// Single cache way storage
`timescale 1ns/1ps
`include "cache_cfg.svh"

module way_ram import cache_pkg::*; #(
	parameter type entry_t = logic
) (
	input  logic   clk,
	input  logic   we,
	input  index_t windex,
	input  entry_t wdata,
	input  index_t rindex,
	output entry_t rdata
);

	// One entry per set, either a tag or a full line depending on entry_t
	entry_t mem [`CACHE_SETS];

	// Writes land on the clock edge
	always_ff @(posedge clk) begin
		if (we)
			mem[windex] <= wdata;
	end

	// Reads are combinational so the lookup can compare in the same cycle
	assign rdata = mem[rindex];

endmodule

/* src/dcache_way_sel.sv */
// Victim and write way select
`timescale 1ns/1ps
`include "cache_cfg.svh"

module dcache_way_sel import cache_pkg::*; (
	input  logic clk,
	input  logic arst_n,
	input  logic store_hit,
	input  way_t hit_way,
	input  logic fill_take,
	output way_t wway
);

	logic [15:0] lfsr;
	logic        feedback;
	way_t        victim;

	// Taps 16, 14, 13, 11 give a maximal length sequence
	assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

	// The low bits serve as a random victim way
	assign victim = lfsr[$bits(way_t)-1:0];

	// ========================================
	// LFSR and write way register
	// ========================================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			lfsr <= `LFSR_SEED;
			wway <= '0;
		end else begin
			// The LFSR free runs, so the victim depends on request timing
			lfsr <= {lfsr[14:0], feedback};
			// A store hit writes back into the way it hit
			if (store_hit) begin
				wway <= hit_way;
			end else if (fill_take) begin
				// A fill replaces whatever the LFSR points at now
				wway <= victim;
			end
		end
	end

endmodule

/* src/dcache_ctrl.sv */
// Data cache controller
`timescale 1ns/1ps
`include "cache_cfg.svh"

module dcache_ctrl import cache_pkg::*, mem_bus_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	// CPU port
	input  logic    cpu_req,
	input  logic    cpu_we,
	input  maddr_t  cpu_addr,
	input  word_t   cpu_wdata,
	output logic    cpu_busy,
	output logic    cpu_done,
	output logic    cpu_hit,
	output word_t   cpu_rdata,
	// Tag and data ways
	input  tag_t    tag_rdata [`CACHE_WAYS],
	input  line_t   line_rdata [`CACHE_WAYS],
	output logic [`CACHE_WAYS-1:0] tag_we,
	output logic [`CACHE_WAYS-1:0] line_we,
	output index_t  windex,
	output tag_t    tag_wdata,
	output line_t   line_wdata,
	output index_t  rindex,
	// Way select
	input  way_t    wway,
	output logic    store_hit,
	output way_t    hit_way,
	output logic    fill_take,
	// Line fill peer
	output logic    fill_start,
	output maddr_t  fill_addr,
	input  logic    fill_we,
	input  offset_t fill_offset,
	input  word_t   fill_word,
	input  logic    fill_done,
	// Store peer
	output logic    st_start,
	output maddr_t  st_addr,
	output word_t   st_data,
	input  logic    st_done
);

	ctrl_state_t state;
	cache_addr_t req_addr;
	logic        req_we;
	word_t       req_wdata;
	logic [`CACHE_SETS-1:0][`CACHE_WAYS-1:0] valid;
	logic [`CACHE_WAYS-1:0] hit_vec;
	logic [`CACHE_WAYS-1:0] wway_sel;
	logic        hit;
	logic        hit_q;
	word_t       rdata_q;
	line_t       fill_line;
	line_t       fill_merged;
	line_t       st_merged;
	logic        fill_end;
	logic        st_update;

	// ========================================
	// Tag compare
	// ========================================

	// All ways are read at the request index and compared at once
	always_comb begin
		hit_vec = '0;
		hit_way = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			hit_vec[w] = valid[req_addr.index][w] && (tag_rdata[w] == req_addr.tag);
			if (hit_vec[w])
				hit_way = way_t'(w);
		end
	end

	assign hit = |hit_vec;

	// One-hot of the latched write way
	always_comb begin
		for (int w = 0; w < `CACHE_WAYS; w++)
			wway_sel[w] = (way_t'(w) == wway);
	end

	// ========================================
	// Line assembly and merge
	// ========================================

	// The last fill word is merged in directly, it is not in fill_line yet
	always_comb begin
		fill_merged = fill_line;
		if (fill_we)
			fill_merged[fill_offset] = fill_word;
	end

	// Store hit replaces one word of the cached line
	always_comb begin
		st_merged = line_rdata[wway];
		st_merged[req_addr.offset] = req_wdata;
	end

	assign fill_end  = (state == FILL) && fill_done;
	assign st_update = (state == STORE) && st_done && hit_q;

	// Way write port
	assign rindex     = req_addr.index;
	assign windex     = req_addr.index;
	assign tag_wdata  = req_addr.tag;
	assign line_wdata = (state == FILL) ? fill_merged : st_merged;
	assign tag_we     = fill_end ? wway_sel : '0;
	assign line_we    = (fill_end || st_update) ? wway_sel : '0;

	// Side requests all come from the single LOOKUP cycle
	assign store_hit  = (state == LOOKUP) && req_we && hit;
	assign fill_take  = (state == LOOKUP) && !req_we && !hit;
	assign fill_start = fill_take;
	assign fill_addr  = maddr_t'({req_addr.tag, req_addr.index, offset_t'(0)});
	assign st_start   = (state == LOOKUP) && req_we;
	assign st_addr    = maddr_t'(req_addr);
	assign st_data    = req_wdata;

	// CPU response
	assign cpu_busy  = (state != IDLE);
	assign cpu_done  = (state == RESPOND);
	assign cpu_hit   = hit_q;
	assign cpu_rdata = rdata_q;

	// ========================================
	// Controller FSM
	// ========================================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			valid <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (cpu_req)
						state <= LOOKUP;
				end
				LOOKUP: begin
					if (req_we)
						state <= STORE;
					else if (hit)
						state <= RESPOND;
					else
						state <= FILL;
				end
				FILL: begin
					// The filled line becomes valid together with its tag
					if (fill_done) begin
						valid[req_addr.index][wway] <= 1'b1;
						state <= RESPOND;
					end
				end
				STORE: begin
					if (st_done)
						state <= RESPOND;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Request capture and response data
	always_ff @(posedge clk) begin
		if (state == IDLE && cpu_req) begin
			req_addr  <= cache_addr_t'(cpu_addr);
			req_we    <= cpu_we;
			req_wdata <= cpu_wdata;
		end
		if (state == LOOKUP) begin
			hit_q   <= hit;
			rdata_q <= line_rdata[hit_way][req_addr.offset];
		end
		// Fill words collect here until the whole line is in
		if (fill_we)
			fill_line[fill_offset] <= fill_word;
		// Miss data comes from the assembled line
		if (fill_end)
			rdata_q <= fill_merged[req_addr.offset];
	end

endmodule

/* src/line_fill.sv */
// Cache line fill unit
`timescale 1ns/1ps
`include "cache_cfg.svh"

module line_fill import cache_pkg::*, mem_bus_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  logic    fill_start,
	input  maddr_t  fill_addr,
	output logic    fill_breq,
	output maddr_t  fill_baddr,
	input  logic    grant,
	input  logic    mem_ack,
	input  word_t   mem_rdata,
	output logic    fill_we,
	output offset_t fill_offset,
	output word_t   fill_word,
	output logic    fill_done
);

	localparam int OFF_W = $bits(offset_t);

	logic                    active;
	logic [`ADDR_W-1:OFF_W]  line_base;
	offset_t                 cnt;
	logic                    beat;
	logic                    last;

	// A beat is an ack on a read we own
	assign beat = grant && mem_ack;
	assign last = (cnt == offset_t'(`LINE_WORDS - 1));

	// Reads walk the line from word 0 upward
	assign fill_breq  = active;
	assign fill_baddr = {line_base, cnt};

	// Each beat goes straight on to the controller
	assign fill_we     = beat;
	assign fill_offset = cnt;
	assign fill_word   = mem_rdata;
	assign fill_done   = beat && last;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			active <= 1'b0;
			cnt    <= '0;
		end else if (fill_start) begin
			active <= 1'b1;
			cnt    <= '0;
		end else if (beat) begin
			cnt <= cnt + 1'b1;
			// Drop the request on the last word
			if (last)
				active <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_start)
			line_base <= fill_addr[`ADDR_W-1:OFF_W];
	end

endmodule

/* src/store_thru.sv */
// Store write-through unit
`timescale 1ns/1ps

module store_thru import mem_bus_pkg::*; (
	input  logic   clk,
	input  logic   arst_n,
	input  logic   st_start,
	input  maddr_t st_addr,
	input  word_t  st_data,
	output logic   st_breq,
	output maddr_t st_baddr,
	output word_t  st_bdata,
	input  logic   grant,
	input  logic   mem_ack,
	output logic   st_done
);

	logic active;

	assign st_breq = active;

	// Request stays up until memory takes the write
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			active  <= 1'b0;
			st_done <= 1'b0;
		end else begin
			st_done <= active && grant && mem_ack;
			if (st_start)
				active <= 1'b1;
			else if (grant && mem_ack)
				active <= 1'b0;
		end
	end

	// Address and data are held steady for the whole request
	always_ff @(posedge clk) begin
		if (st_start) begin
			st_baddr <= st_addr;
			st_bdata <= st_data;
		end
	end

endmodule

/* src/mem_arbiter.sv */
// Memory bus arbiter
`timescale 1ns/1ps

module mem_arbiter import mem_bus_pkg::*; (
	input  logic   clk,
	input  logic   arst_n,
	input  logic   fill_breq,
	input  maddr_t fill_baddr,
	input  logic   st_breq,
	input  maddr_t st_baddr,
	input  word_t  st_bdata,
	output logic   fill_grant,
	output logic   st_grant,
	output logic   mem_req,
	output logic   mem_we,
	output maddr_t mem_addr,
	output word_t  mem_wdata,
	input  logic   mem_ack
);

	logic   locked;
	owner_t owner;

	// Owner is locked in from grant until its ack
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			locked <= 1'b0;
			owner  <= OWN_FILL;
		end else if (locked) begin
			if (mem_ack)
				locked <= 1'b0;
		end else if (st_breq) begin
			// Store wins a tie
			owner  <= OWN_STORE;
			locked <= 1'b1;
		end else if (fill_breq) begin
			owner  <= OWN_FILL;
			locked <= 1'b1;
		end
	end

	assign fill_grant = locked && (owner == OWN_FILL);
	assign st_grant   = locked && (owner == OWN_STORE);

	// The bus shows the owner's request
	assign mem_req   = locked;
	assign mem_we    = st_grant;
	assign mem_addr  = (owner == OWN_STORE) ? st_baddr : fill_baddr;
	assign mem_wdata = st_bdata;

endmodule

/* src/dcache_top.sv */
// Data cache top level
`timescale 1ns/1ps
`include "cache_cfg.svh"

module dcache_top import cache_pkg::*, mem_bus_pkg::*; (
	input  logic   clk,
	input  logic   arst_n,
	// CPU port
	input  logic   cpu_req,
	input  logic   cpu_we,
	input  maddr_t cpu_addr,
	input  word_t  cpu_wdata,
	output logic   cpu_busy,
	output logic   cpu_done,
	output logic   cpu_hit,
	output word_t  cpu_rdata,
	// Memory bus
	output logic   mem_req,
	output logic   mem_we,
	output maddr_t mem_addr,
	output word_t  mem_wdata,
	input  logic   mem_ack,
	input  word_t  mem_rdata
);

	tag_t    tag_rd [`CACHE_WAYS];
	line_t   line_rd [`CACHE_WAYS];
	logic [`CACHE_WAYS-1:0] tag_we;
	logic [`CACHE_WAYS-1:0] line_we;
	index_t  windex;
	index_t  rindex;
	tag_t    tag_wd;
	line_t   line_wd;
	way_t    wway;
	way_t    hit_way;
	logic    store_hit;
	logic    fill_take;
	logic    fill_start;
	maddr_t  fill_addr;
	logic    fill_we;
	offset_t fill_offset;
	word_t   fill_word;
	logic    fill_done;
	logic    st_start;
	maddr_t  st_addr;
	word_t   st_data;
	logic    st_done;
	logic    fill_breq;
	maddr_t  fill_baddr;
	logic    fill_grant;
	logic    st_breq;
	maddr_t  st_baddr;
	word_t   st_bdata;
	logic    st_grant;

	dcache_ctrl u_ctrl (
		.clk(clk), .arst_n(arst_n),
		.cpu_req(cpu_req), .cpu_we(cpu_we), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
		.cpu_busy(cpu_busy), .cpu_done(cpu_done), .cpu_hit(cpu_hit), .cpu_rdata(cpu_rdata),
		.tag_rdata(tag_rd), .line_rdata(line_rd), .tag_we(tag_we), .line_we(line_we),
		.windex(windex), .tag_wdata(tag_wd), .line_wdata(line_wd), .rindex(rindex),
		.wway(wway), .store_hit(store_hit), .hit_way(hit_way), .fill_take(fill_take),
		.fill_start(fill_start), .fill_addr(fill_addr), .fill_we(fill_we),
		.fill_offset(fill_offset), .fill_word(fill_word), .fill_done(fill_done),
		.st_start(st_start), .st_addr(st_addr), .st_data(st_data), .st_done(st_done)
	);

	// Each way keeps its tags and its lines in separate arrays
	for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
		way_ram #(.entry_t(tag_t)) u_tag (
			.clk(clk), .we(tag_we[w]), .windex(windex), .wdata(tag_wd),
			.rindex(rindex), .rdata(tag_rd[w])
		);
		way_ram #(.entry_t(line_t)) u_line (
			.clk(clk), .we(line_we[w]), .windex(windex), .wdata(line_wd),
			.rindex(rindex), .rdata(line_rd[w])
		);
	end

	dcache_way_sel u_way_sel (
		.clk(clk), .arst_n(arst_n), .store_hit(store_hit), .hit_way(hit_way),
		.fill_take(fill_take), .wway(wway)
	);

	line_fill u_line_fill (
		.clk(clk), .arst_n(arst_n), .fill_start(fill_start), .fill_addr(fill_addr),
		.fill_breq(fill_breq), .fill_baddr(fill_baddr), .grant(fill_grant),
		.mem_ack(mem_ack), .mem_rdata(mem_rdata), .fill_we(fill_we),
		.fill_offset(fill_offset), .fill_word(fill_word), .fill_done(fill_done)
	);

	store_thru u_store_thru (
		.clk(clk), .arst_n(arst_n), .st_start(st_start), .st_addr(st_addr),
		.st_data(st_data), .st_breq(st_breq), .st_baddr(st_baddr), .st_bdata(st_bdata),
		.grant(st_grant), .mem_ack(mem_ack), .st_done(st_done)
	);

	mem_arbiter u_arbiter (
		.clk(clk), .arst_n(arst_n), .fill_breq(fill_breq), .fill_baddr(fill_baddr),
		.st_breq(st_breq), .st_baddr(st_baddr), .st_bdata(st_bdata),
		.fill_grant(fill_grant), .st_grant(st_grant), .mem_req(mem_req),
		.mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_ack(mem_ack)
	);

endmodule

/* testbench/dcache_sva.sv */
// Cache protocol assertions
`timescale 1ns/1ps

module dcache_sva import mem_bus_pkg::*; (
	input logic   clk,
	input logic   arst_n,
	input logic   cpu_req,
	input logic   cpu_busy,
	input logic   cpu_done,
	input logic   mem_req,
	input maddr_t mem_addr,
	input logic   mem_ack
);

	// A bus request holds its address until memory acks it
	a_mem_hold: assert property (@(posedge clk) disable iff (!arst_n)
		mem_req && !mem_ack |=> mem_req && $stable(mem_addr))
		else $error("mem_req or mem_addr changed before mem_ack");

	// Completion is a single cycle strobe
	a_done_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		cpu_done |=> !cpu_done)
		else $error("cpu_done lasted more than one cycle");

	// An accepted request raises busy in the next cycle
	a_busy_rise: assert property (@(posedge clk) disable iff (!arst_n)
		cpu_req && !cpu_busy |=> cpu_busy)
		else $error("cpu_busy did not rise after a request");

	// Busy only falls after the done strobe
	a_busy_hold: assert property (@(posedge clk) disable iff (!arst_n)
		cpu_busy && !cpu_done |=> cpu_busy)
		else $error("cpu_busy fell before cpu_done");

endmodule

bind dcache_top dcache_sva u_sva (
	.clk(clk), .arst_n(arst_n), .cpu_req(cpu_req), .cpu_busy(cpu_busy),
	.cpu_done(cpu_done), .mem_req(mem_req), .mem_addr(mem_addr), .mem_ack(mem_ack)
);

/* testbench/tb_dcache.sv */
// Data cache testbench
`timescale 1ns/1ps
`include "cache_cfg.svh"

module tb_dcache import mem_bus_pkg::*; ();

	localparam logic [31:0] SEED = 32'd36117;
	localparam int N_RAND = 400;
	localparam int REGION = 256;
	localparam int NLINES = REGION / `LINE_WORDS;
	// A fill word costs a regrant cycle, up to 3 waits and the ack, plus FSM overhead
	localparam int WORST_ACCESS = 6 * `LINE_WORDS + 12;
	localparam int CYCLE_LIMIT = (N_RAND + 16) * WORST_ACCESS + 50;

	logic   clk;
	logic   arst_n;
	logic   cpu_req;
	logic   cpu_we;
	maddr_t cpu_addr;
	word_t  cpu_wdata;
	logic   cpu_busy;
	logic   cpu_done;
	logic   cpu_hit;
	word_t  cpu_rdata;
	logic   mem_req;
	logic   mem_we;
	maddr_t mem_addr;
	word_t  mem_wdata;
	logic   mem_ack = 1'b0;
	word_t  mem_rdata = '0;

	// Memory model state and traffic counters
	word_t       mem [REGION];
	logic [31:0] mem_state;
	logic        serving = 1'b0;
	int          wait_left = 0;
	int          reads = 0;
	int          writes = 0;
	int          req_cycles = 0;
	maddr_t      read_log [$];
	maddr_t      last_waddr;
	word_t       last_wdata;

	// Reference model: shadow memory, lines ever loaded, line of the last load
	word_t       model [REGION];
	bit          loaded [NLINES];
	int          resident;
	int          last_load;
	logic [31:0] stim_state;
	int          cycles = 0;

	dcache_top u_dcache_top (
		.clk(clk), .arst_n(arst_n),
		.cpu_req(cpu_req), .cpu_we(cpu_we), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
		.cpu_busy(cpu_busy), .cpu_done(cpu_done), .cpu_hit(cpu_hit), .cpu_rdata(cpu_rdata),
		.mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_ack(mem_ack), .mem_rdata(mem_rdata)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Upper LCG bits are the better random ones
	function automatic logic [15:0] stim_rand();
		stim_state = lcg_step(stim_state);
		return stim_state[31:16];
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("Errors found");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the test did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Errors found");
			$fatal(1, "cycle limit reached");
		end
	end

	// ========================================
	// Memory model
	// ========================================

	// Acks come on the falling edge after 0 to 3 random wait cycles
	always @(negedge clk) begin
		mem_ack = 1'b0;
		if (mem_req) begin
			req_cycles++;
			if (!serving) begin
				serving = 1'b1;
				mem_state = lcg_step(mem_state);
				wait_left = int'(mem_state[17:16]);
			end
			if (wait_left == 0) begin
				compare_value("mem_addr[15:8]", 32'(mem_addr[15:8]), 32'd0);
				if (mem_we) begin
					mem[mem_addr[7:0]] = mem_wdata;
					writes++;
					last_waddr = mem_addr;
					last_wdata = mem_wdata;
				end else begin
					mem_rdata = mem[mem_addr[7:0]];
					reads++;
					read_log.push_back(mem_addr);
				end
				mem_ack = 1'b1;
				serving = 1'b0;
			end else begin
				wait_left--;
			end
		end
	end

	// ========================================
	// One CPU access with its checks
	// ========================================

	task automatic do_access(input logic we, input int addr, input word_t wdata);
		int   line;
		int   lat;
		int   reads0;
		int   writes0;
		int   reqs0;
		logic hit_known;
		logic exp_hit;
		while (cpu_busy)
			@(negedge clk);
		line = addr / `LINE_WORDS;
		// The last loaded line stays put across stores, and an unloaded line cannot hit
		hit_known = (line == resident) || !loaded[line];
		exp_hit = (line == resident);
		reads0 = reads;
		writes0 = writes;
		reqs0 = req_cycles;
		read_log.delete();
		cpu_req = 1'b1;
		cpu_we = we;
		cpu_addr = maddr_t'(addr);
		cpu_wdata = wdata;
		@(negedge clk);
		cpu_req = 1'b0;
		lat = 1;
		while (!cpu_done) begin
			@(negedge clk);
			lat++;
		end
		if (hit_known)
			compare_value("cpu_hit", 32'(cpu_hit), 32'(exp_hit));
		if (we) begin
			model[addr] = wdata;
			compare_value("write count", 32'(writes - writes0), 32'd1);
			compare_value("read count", 32'(reads - reads0), 32'd0);
			compare_value("mem write addr", 32'(last_waddr), 32'(addr));
			compare_value("mem write data", last_wdata, wdata);
		end else begin
			compare_value("cpu_rdata", cpu_rdata, model[addr]);
			compare_value("write count", 32'(writes - writes0), 32'd0);
			if (cpu_hit) begin
				compare_value("hit latency", 32'(lat), 32'd2);
				compare_value("mem_req cycles", 32'(req_cycles - reqs0), 32'd0);
			end else begin
				// A miss reads the whole line in order from its base
				compare_value("read count", 32'(reads - reads0), 32'(`LINE_WORDS));
				for (int i = 0; i < read_log.size(); i++)
					compare_value("fill addr", 32'(read_log[i]), 32'(line * `LINE_WORDS + i));
			end
			loaded[line] = 1'b1;
			resident = line;
			last_load = addr;
		end
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial begin
		int     gap;
		int     addr;
		logic   we;
		word_t  wdata;
		cpu_req = 1'b0;
		cpu_we = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		arst_n = 1'b0;
		stim_state = SEED;
		mem_state = SEED;
		resident = -1;
		last_load = -1;
		for (int a = 0; a < REGION; a++) begin
			mem[a] = 32'hD00D_0000 + 32'(a) * 32'h0001_0101;
			model[a] = mem[a];
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);

		// Cold miss, repeat hit, same line hit, store hit and reload of the new word
		do_access(1'b0, 'h10, '0);
		do_access(1'b0, 'h10, '0);
		do_access(1'b0, 'h13, '0);
		do_access(1'b1, 'h11, 32'hCAFE_F00D);
		do_access(1'b0, 'h11, '0);
		// Store miss does not allocate, so the later load still fills
		do_access(1'b1, 'h80, 32'h1234_5678);
		do_access(1'b0, 'h80, '0);
		do_access(1'b0, 'h81, '0);

		for (int n = 0; n < N_RAND; n++) begin
			if (stim_rand() % 8 == 0 && last_load >= 0) begin
				we = 1'b0;
				addr = last_load;
			end else begin
				we = (stim_rand() % 3 == 0);
				addr = int'(stim_rand() % REGION);
			end
			wdata = {stim_rand(), stim_rand()};
			do_access(we, addr, wdata);
			gap = int'(stim_rand() % 3);
			repeat (gap) @(negedge clk);
		end

		$display("No errors");
		$finish;
	end

endmodule

/* files.f */
+incdir+src
src/cache_pkg.sv
src/mem_bus_pkg.sv
src/way_ram.sv
src/dcache_way_sel.sv
src/dcache_ctrl.sv
src/line_fill.sv
src/store_thru.sv
src/mem_arbiter.sv
src/dcache_top.sv
testbench/dcache_sva.sv
testbench/tb_dcache.sv

/* run.sh */
#!/usr/bin/env bash
# Build the data cache simulation with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f files.f --top-module tb_dcache \
	-Mdir obj_dir -o sim_dcache
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_dcache 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "No errors"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
